// File: executePkg.sv
package executePkg;

    localparam int dataWidth = 32;
    localparam int mdSteps   = 32;

    ////////////////////////////////////////////////// opcodes
    localparam logic [5:0] opcSpecial = 6'b000000;
    localparam logic [5:0] opcAddi    = 6'b001000;
    localparam logic [5:0] opcAddiu   = 6'b001001;
    localparam logic [5:0] opcSlti    = 6'b001010;
    localparam logic [5:0] opcSltiu   = 6'b001011;
    localparam logic [5:0] opcAndi    = 6'b001100;
    localparam logic [5:0] opcOri     = 6'b001101;
    localparam logic [5:0] opcXori    = 6'b001110;
    localparam logic [5:0] opcLui     = 6'b001111;
    localparam logic [5:0] opcLw      = 6'b100011;
    localparam logic [5:0] opcSw      = 6'b101011;

    ////////////////////////////////////////////////// function field
    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnSrl   = 6'b000010;
    localparam logic [5:0] fnSra   = 6'b000011;
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrlv  = 6'b000110;
    localparam logic [5:0] fnSrav  = 6'b000111;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnDiv   = 6'b011010;
    localparam logic [5:0] fnDivu  = 6'b011011;
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnSubu  = 6'b100011;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    typedef enum logic [3:0] {
        opAnd, opOr, opXor, opNor,
        opAdd, opAddU, opSub, opSubU,
        opSlt, opSltU, opSll, opSrl, opSra, opLui
    } aluOpT;

    typedef enum logic [1:0] {destRt, destRd, destNone} destSelT;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        mdNone, mdMult, mdMultU, mdDiv, mdDivU,
        mdMoveHi, mdMoveLo, mdReadHi, mdReadLo
    } mdKindT;

    typedef enum logic [1:0] {seqIdle, seqRun, seqDone} seqStateT;

endpackage

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import executePkg::*; (
    input  logic [dataWidth-1:0] instr,
    output aluOpT                aluOp,
    output logic [dataWidth-1:0] immValue,
    output logic                 useImm,
    output logic [4:0]           writeReg,
    output logic                 writeEnable,
    output mdKindT               mdKind
);

    destSelT    destSel;
    logic       signExt;
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb
    begin
        aluOp   = opAddU; // no overflow for non-ALU instructions
        useImm  = 1'b0;
        destSel = destNone;
        mdKind  = mdNone;
        signExt = 1'b1;
        case (opcode)
            opcSpecial:
            begin
                destSel = destRd;
                case (funct)
                    fnAdd:   aluOp = opAdd;
                    fnAddu:  aluOp = opAddU;
                    fnSub:   aluOp = opSub;
                    fnSubu:  aluOp = opSubU;
                    fnAnd:   aluOp = opAnd;
                    fnOr:    aluOp = opOr;
                    fnXor:   aluOp = opXor;
                    fnNor:   aluOp = opNor;
                    fnSlt:   aluOp = opSlt;
                    fnSltu:  aluOp = opSltU;
                    fnSll, fnSllv: aluOp = opSll;
                    fnSrl, fnSrlv: aluOp = opSrl;
                    fnSra, fnSrav: aluOp = opSra;
                    fnMfhi:  mdKind = mdReadHi;
                    fnMflo:  mdKind = mdReadLo;
                    fnMthi:
                    begin
                        mdKind  = mdMoveHi;
                        destSel = destNone;
                    end
                    fnMtlo:
                    begin
                        mdKind  = mdMoveLo;
                        destSel = destNone;
                    end
                    fnMult, fnMultu, fnDiv, fnDivu:
                    begin
                        mdKind  = (funct == fnMult)  ? mdMult :
                                  (funct == fnMultu) ? mdMultU :
                                  (funct == fnDiv)   ? mdDiv : mdDivU;
                        destSel = destNone;
                    end
                    default: destSel = destNone; // unknown funct
                endcase
            end
            opcAddi:  begin aluOp = opAdd;  useImm = 1'b1; destSel = destRt; end
            opcAddiu: begin aluOp = opAddU; useImm = 1'b1; destSel = destRt; end
            opcSlti:  begin aluOp = opSlt;  useImm = 1'b1; destSel = destRt; end
            opcSltiu: begin aluOp = opSltU; useImm = 1'b1; destSel = destRt; end
            opcAndi:  begin aluOp = opAnd;  useImm = 1'b1; destSel = destRt; signExt = 1'b0; end
            opcOri:   begin aluOp = opOr;   useImm = 1'b1; destSel = destRt; signExt = 1'b0; end
            opcXori:  begin aluOp = opXor;  useImm = 1'b1; destSel = destRt; signExt = 1'b0; end
            opcLui:   begin aluOp = opLui;  useImm = 1'b1; destSel = destRt; signExt = 1'b0; end
            opcLw:    begin useImm = 1'b1; destSel = destRt; end // address sum only
            opcSw:    useImm = 1'b1;
            default:  destSel = destNone;
        endcase
    end

    assign immValue    = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
    assign writeReg    = (destSel == destRd) ? instr[15:11] : instr[20:16];
    assign writeEnable = (destSel != destNone) && (writeReg != 5'd0); // $0 never written

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import executePkg::*; (
    input  aluOpT                aluOp,
    input  logic [dataWidth-1:0] srcA,
    input  logic [dataWidth-1:0] srcB,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] aluResult,
    output logic                 overflow
);

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic                 addOvf;
    logic                 subOvf;

    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;

    // same-sign inputs, sign flipped in sum
    assign addOvf = (srcA[dataWidth-1] == srcB[dataWidth-1])
                    && (sum[dataWidth-1] != srcA[dataWidth-1]);
    assign subOvf = (srcA[dataWidth-1] != srcB[dataWidth-1])
                    && (diff[dataWidth-1] != srcA[dataWidth-1]);

    always_comb
    begin
        case (aluOp)
            opAnd:   aluResult = srcA & srcB;
            opOr:    aluResult = srcA | srcB;
            opXor:   aluResult = srcA ^ srcB;
            opNor:   aluResult = ~(srcA | srcB);
            opAdd,
            opAddU:  aluResult = sum;
            opSub,
            opSubU:  aluResult = diff;
            opSlt:   aluResult = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            opSltU:  aluResult = {{(dataWidth-1){1'b0}}, srcA < srcB};
            opSll:   aluResult = srcB << shamt;
            opSrl:   aluResult = srcB >> shamt;
            opSra:   aluResult = $signed(srcB) >>> shamt;
            opLui:   aluResult = srcB << 16;
            default: aluResult = sum;
        endcase
    end

    always_comb
    begin
        case (aluOp)
            opAdd:   overflow = addOvf;
            opSub:   overflow = subOvf;
            default: overflow = 1'b0; // unsigned forms never trap
        endcase
    end

endmodule

// File: mulDivSequencer.sv
`timescale 1ns/1ps

module mulDivSequencer import executePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  mdKindT kind,
    input  logic   lastStep,
    input  logic   outFree,
    output logic   load,
    output logic   step,
    output logic   finish,
    output logic   busy,
    output logic   done
);

    seqStateT state;
    seqStateT nextState;
    logic     isArith;

    assign isArith = (kind == mdMult) || (kind == mdMultU)
                     || (kind == mdDiv) || (kind == mdDivU);

    assign load   = (state == seqIdle) && start && isArith;
    assign step   = (state == seqRun);
    assign finish = (state == seqDone) && outFree; // wait for output slot
    assign busy   = (state != seqIdle) || done;

    always_comb
    begin
        nextState = state;
        case (state)
            seqIdle: if (load)     nextState = seqRun;
            seqRun:  if (lastStep) nextState = seqDone;
            seqDone: if (finish)   nextState = seqIdle;
            default: nextState = seqIdle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= seqIdle;
            done  <= 1'b0;
        end
        else
        begin
            state <= nextState;
            done  <= finish; // HI/LO settled, hand to output reg
        end
    end

endmodule

// File: iterationCounter.sv
`timescale 1ns/1ps

module iterationCounter import executePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic enable,
    output logic lastStep
);

    localparam int countWidth = $clog2(mdSteps);

    logic [countWidth-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset || clear)
            count <= '0;
        else if (enable)
            count <= count + 1'b1; // wraps back to 0 after last step
    end

    assign lastStep = (count == countWidth'(mdSteps - 1));

endmodule

// File: hiLoDatapath.sv
`timescale 1ns/1ps

module hiLoDatapath import executePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  mdKindT               kind,
    input  logic                 load,
    input  logic                 step,
    input  logic                 finish,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic                 moveHi,
    input  logic                 moveLo,
    input  logic [dataWidth-1:0] moveValue,
    output logic [dataWidth-1:0] hiValue,
    output logic [dataWidth-1:0] loValue
);

    logic                   signedKind;
    logic                   divKind;
    logic [dataWidth-1:0]   absA;
    logic [dataWidth-1:0]   absB;
    logic                   isDiv;
    logic                   negLo;
    logic                   negHi;
    logic [dataWidth-1:0]   workHi;  // product high / remainder
    logic [dataWidth-1:0]   workLo;  // multiplier / dividend then quotient
    logic [dataWidth-1:0]   operandB;
    logic [dataWidth:0]     mulSum;
    logic [dataWidth:0]     divShift;
    logic [dataWidth:0]     divTrial;
    logic [2*dataWidth-1:0] product;

    assign signedKind = (kind == mdMult) || (kind == mdDiv);
    assign divKind    = (kind == mdDiv) || (kind == mdDivU);
    assign absA = (signedKind && opA[dataWidth-1]) ? -opA : opA;
    assign absB = (signedKind && opB[dataWidth-1]) ? -opB : opB;

    ////////////////////////////////////////////////// one iteration
    assign mulSum   = {1'b0, workHi} + (workLo[0] ? {1'b0, operandB} : '0);
    assign divShift = {workHi, workLo[dataWidth-1]};
    assign divTrial = divShift - {1'b0, operandB}; // msb set means restore
    assign product  = {workHi, workLo};

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            isDiv    <= divKind;
            negLo    <= signedKind && (opA[dataWidth-1] ^ opB[dataWidth-1]);
            negHi    <= signedKind && opA[dataWidth-1];
            workHi   <= '0;
            workLo   <= absA;
            operandB <= absB;
        end
        else if (step && isDiv)
        begin
            workHi <= divTrial[dataWidth] ? divShift[dataWidth-1:0] : divTrial[dataWidth-1:0];
            workLo <= {workLo[dataWidth-2:0], ~divTrial[dataWidth]};
        end
        else if (step)
        begin
            workHi <= mulSum[dataWidth:1];
            workLo <= {mulSum[0], workLo[dataWidth-1:1]};
        end
    end

    ////////////////////////////////////////////////// HI and LO
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hiValue <= '0;
            loValue <= '0;
        end
        else if (finish && isDiv)
        begin
            loValue <= negLo ? -workLo : workLo; // quotient
            hiValue <= negHi ? -workHi : workHi; // remainder follows dividend
        end
        else if (finish)
            {hiValue, loValue} <= negLo ? -product : product;
        else
        begin
            if (moveHi)
                hiValue <= moveValue;
            if (moveLo)
                loValue <= moveValue;
        end
    end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage import executePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [dataWidth-1:0] instr,
    input  logic [dataWidth-1:0] rsValue,
    input  logic [dataWidth-1:0] rtValue,
    input  logic                 inValid,
    output logic                 inReady,
    output logic [dataWidth-1:0] result,
    output logic [4:0]           writeReg,
    output logic                 writeEnable,
    output logic                 overflow,
    output logic                 outValid,
    input  logic                 outReady
);

    aluOpT                aluOp;
    mdKindT               mdKind;
    logic [dataWidth-1:0] immValue;
    logic                 useImm;
    logic [4:0]           decWriteReg;
    logic                 decWriteEnable;
    logic [dataWidth-1:0] srcB;
    logic [4:0]           shiftAmount;
    logic [dataWidth-1:0] aluResult;
    logic                 aluOverflow;
    logic [dataWidth-1:0] hiValue;
    logic [dataWidth-1:0] loValue;
    logic [dataWidth-1:0] stageResult;
    logic                 inFire, outFree, loadOut;
    logic                 load, step, finish, busy, mdDone, lastStep;

    assign outFree = !outValid || outReady;
    assign inReady = outFree && !busy;
    assign inFire  = inValid && inReady;
    assign loadOut = mdDone || (inFire && !load); // mult/div reports later

    assign srcB        = useImm ? immValue : rtValue;
    assign shiftAmount = instr[2] ? rsValue[4:0] : instr[10:6]; // sllv/srlv/srav

    always_comb
    begin
        case (mdKind)
            mdReadHi:           stageResult = hiValue;
            mdReadLo:           stageResult = loValue;
            mdMoveHi, mdMoveLo: stageResult = rsValue;
            default:            stageResult = aluResult;
        endcase
    end

    instrDecoder i_instrDecoder (
        .instr(instr), .aluOp(aluOp), .immValue(immValue), .useImm(useImm),
        .writeReg(decWriteReg), .writeEnable(decWriteEnable), .mdKind(mdKind)
    );

    alu i_alu (
        .aluOp(aluOp), .srcA(rsValue), .srcB(srcB), .shamt(shiftAmount),
        .aluResult(aluResult), .overflow(aluOverflow)
    );

    mulDivSequencer i_mulDivSequencer (
        .clk(clk), .reset(reset), .start(inFire), .kind(mdKind), .lastStep(lastStep),
        .outFree(outFree), .load(load), .step(step), .finish(finish),
        .busy(busy), .done(mdDone)
    );

    iterationCounter i_iterationCounter (
        .clk(clk), .reset(reset), .clear(load), .enable(step), .lastStep(lastStep)
    );

    hiLoDatapath i_hiLoDatapath (
        .clk(clk), .reset(reset), .kind(mdKind), .load(load), .step(step),
        .finish(finish), .opA(rsValue), .opB(rtValue),
        .moveHi(inFire && (mdKind == mdMoveHi)), .moveLo(inFire && (mdKind == mdMoveLo)),
        .moveValue(rsValue), .hiValue(hiValue), .loValue(loValue)
    );

    ////////////////////////////////////////////////// output register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid    <= 1'b0;
            writeEnable <= 1'b0;
            overflow    <= 1'b0;
        end
        else if (loadOut)
        begin
            outValid    <= 1'b1;
            writeEnable <= !mdDone && decWriteEnable;
            overflow    <= !mdDone && aluOverflow;
        end
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (loadOut)
        begin
            result   <= mdDone ? loValue : stageResult;
            writeReg <= mdDone ? 5'd0 : decWriteReg;
        end
    end

endmodule

// File: executeStage_tb.sv
`timescale 1ns/1ps

module executeStage_tb;

    localparam int          vecWords   = 7;   // fields per vector line
    localparam int          maxVectors = 64;
    localparam int          stallLimit = 200; // cycles per handshake wait
    localparam int          drainCycles = 40; // longer than a mult/div
    localparam logic [31:0] endMarker  = 32'hffffffff;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic        inValid;
    logic        inReady;
    logic [31:0] result;
    logic [4:0]  writeReg;
    logic        writeEnable;
    logic        overflow;
    logic        outValid;
    logic        outReady;

    logic [31:0] vecMem [0:511];
    int          numVectors;
    int          errorCount;
    int          seed;
    logic        stalled;

    executeStage i_executeStage (
        .clk(clk), .reset(reset), .instr(instr), .rsValue(rsValue), .rtValue(rtValue),
        .inValid(inValid), .inReady(inReady), .result(result), .writeReg(writeReg),
        .writeEnable(writeEnable), .overflow(overflow), .outValid(outValid),
        .outReady(outReady)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure on the output side
    initial
    begin
        outReady = 1'b0;
        seed     = 32'h9e057b5c;
        forever
        begin
            @(posedge clk);
            #1;
            outReady = ($random(seed) & 3) != 0; // low about one cycle in four
        end
    end

    function automatic logic [31:0] vecField(input int idx, input int field);
        logic [8:0] addr;
        addr = 9'(idx * vecWords + field);
        return vecMem[addr];
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            errorCount++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // input side
    task automatic driveInputs();
        int idx;
        int waitCycles;
        idx = 0;
        while (idx < numVectors && !stalled)
        begin
            instr      = vecField(idx, 0);
            rsValue    = vecField(idx, 1);
            rtValue    = vecField(idx, 2);
            inValid    = 1'b1;
            waitCycles = 0;
            @(negedge clk);
            while (!inReady && !stalled && waitCycles < stallLimit)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (!inReady)
            begin
                if (!stalled)
                begin
                    errorCount++;
                    $display("input stalled: vector %0d not accepted within %0d cycles",
                             idx, stallLimit);
                end
                stalled = 1'b1;
            end
            else
            begin
                @(posedge clk); // transfer edge
                #1;
                idx++;
            end
        end
        inValid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // output side, one result per vector in order
    task automatic collectOutputs();
        int idx;
        int waitCycles;
        idx = 0;
        while (idx < numVectors && !stalled)
        begin
            waitCycles = 0;
            @(negedge clk);
            while (!(outValid && outReady) && !stalled && waitCycles < stallLimit)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (!(outValid && outReady))
            begin
                if (!stalled)
                begin
                    errorCount++;
                    $display("output stalled: no result for vector %0d within %0d cycles",
                             idx, stallLimit);
                end
                stalled = 1'b1;
            end
            else
            begin
                checkValue($sformatf("vector %0d result", idx), result, vecField(idx, 3));
                checkValue($sformatf("vector %0d writeReg", idx), {27'b0, writeReg},
                           vecField(idx, 4));
                checkValue($sformatf("vector %0d writeEnable", idx), {31'b0, writeEnable},
                           vecField(idx, 5));
                checkValue($sformatf("vector %0d overflow", idx), {31'b0, overflow},
                           vecField(idx, 6));
                @(posedge clk);
                idx++;
            end
        end
    endtask

    task automatic checkNoExtraOutput();
        int   cycle;
        logic seen;
        cycle = 0;
        seen  = 1'b0;
        while (cycle < drainCycles && !seen)
        begin
            @(negedge clk);
            if (outValid)
                seen = 1'b1;
            cycle++;
        end
        if (seen)
        begin
            errorCount++;
            $display("an extra output appeared after the last vector");
        end
    endtask

    //////////////////////////////////////////////////
    initial
    begin
        reset      = 1'b1;
        instr      = '0;
        rsValue    = '0;
        rtValue    = '0;
        inValid    = 1'b0;
        errorCount = 0;
        stalled    = 1'b0;
        numVectors = 0;
        $readmemh("execute_vectors.txt", vecMem);
        while (numVectors < maxVectors && vecField(numVectors, 0) !== endMarker)
            numVectors++;
        if (numVectors == 0 || numVectors == maxVectors)
        begin
            errorCount++;
            $display("vector file is empty or has no end marker");
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("inReady after reset", {31'b0, inReady}, 32'd1);
        checkValue("outValid after reset", {31'b0, outValid}, 32'd0);
        checkValue("writeEnable after reset", {31'b0, writeEnable}, 32'd0);

        if (errorCount == 0)
        begin
            fork
                driveInputs();
                collectOutputs();
            join
            if (!stalled)
                checkNoExtraOutput();
        end

        $display("%0d errors over %0d vectors", errorCount, numVectors);
        if (errorCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: execute_vectors.txt
// columns: instr rsValue rtValue result writeReg writeEnable overflow (all hex)
// one instruction per line, an instr of ffffffff ends the list
00221820 00000005 00000007 0000000c 03 1 0
00221820 7fffffff 00000001 80000000 03 1 1
00221821 7fffffff 00000001 80000000 03 1 0
00221822 80000000 00000001 7fffffff 03 1 1
00221823 80000000 00000001 7fffffff 03 1 0
00221824 f0f0ff00 0ff0f0f0 00f0f000 03 1 0
00221825 f0f0ff00 0ff0f0f0 fff0fff0 03 1 0
00221826 f0f0ff00 0ff0f0f0 ff000ff0 03 1 0
00221827 f0f0ff00 0ff0f0f0 000f000f 03 1 0
0022182a fffffffe 00000001 00000001 03 1 0
0022182b fffffffe 00000001 00000000 03 1 0
00021900 00000000 0000000f 000000f0 03 1 0
00021a03 00000000 80000000 ff800000 03 1 0
00221806 00000024 f0000000 0f000000 03 1 0
00221807 0000001f 80000000 ffffffff 03 1 0
2024ffff 80000000 00000000 7fffffff 04 1 1
2424ffff 00000010 00000000 0000000f 04 1 0
2824fff0 ffffffe0 00000000 00000001 04 1 0
2c24fff0 fffffff8 00000000 00000000 04 1 0
3024ff0f ffffffff 00000000 0000ff0f 04 1 0
34248000 12340000 00000000 12348000 04 1 0
3824ffff ffff0000 00000000 ffffffff 04 1 0
3c04abcd 00000000 00000000 abcd0000 04 1 0
8c240008 00001000 00000000 00001008 04 1 0
ac24fffc 00001000 00000000 00000ffc 04 0 0
24200005 00000001 00000000 00000006 00 0 0
00220018 fffffffd 00000007 ffffffeb 00 0 0
00001810 00000000 00000000 ffffffff 03 1 0
00001812 00000000 00000000 ffffffeb 03 1 0
00220018 fffffffe 80000000 00000000 00 0 0
00001810 00000000 00000000 00000001 03 1 0
00001812 00000000 00000000 00000000 03 1 0
00220019 ffffffff ffffffff 00000001 00 0 0
00001810 00000000 00000000 fffffffe 03 1 0
00001812 00000000 00000000 00000001 03 1 0
0022001a fffffff9 00000002 fffffffd 00 0 0
00001810 00000000 00000000 ffffffff 03 1 0
00001812 00000000 00000000 fffffffd 03 1 0
0022001b 00000064 00000000 ffffffff 00 0 0
00001810 00000000 00000000 00000064 03 1 0
00001812 00000000 00000000 ffffffff 03 1 0
00200011 cafef00d 00000000 cafef00d 00 0 0
00200013 12345678 00000000 12345678 00 0 0
00001810 00000000 00000000 cafef00d 03 1 0
00001812 00000000 00000000 12345678 03 1 0
00000010 00000000 00000000 cafef00d 00 0 0
ffffffff 00000000 00000000 00000000 00 0 0

// File: project.f
executePkg.sv
instrDecoder.sv
alu.sv
mulDivSequencer.sv
iterationCounter.sv
hiLoDatapath.sv
executeStage.sv
executeStage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= executeStage_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
